/* hw/cordic_settings.svh */
`ifndef CORDIC_SETTINGS_SVH
`define CORDIC_SETTINGS_SVH

// ======================================================================
// Fixed-point format shared by X, Y, Z, angle and result
// ======================================================================
`define CORDIC_W          16        // Data width with sign
`define CORDIC_FRAC       14        // Fraction bits of the Q2.14 format

// ======================================================================
// Iteration control
// ======================================================================
`define CORDIC_ITER_BITS  4         // Counter width for 16 micro-rotations

// Start value of X carries the inverse CORDIC gain
// so the final vector comes out with unit length
`define CORDIC_X0         9949      // 0.607252935 in Q2.14

`endif

/* hw/cordic_pkg.sv */
`include "cordic_settings.svh"

package cordic_pkg;

    typedef logic signed [`CORDIC_W-1:0]        fix_t;     // X, Y, Z, angle and result
    typedef logic        [`CORDIC_ITER_BITS-1:0] iter_t;   // Micro-rotation index
    typedef logic        [1:0]                   region_t; // Angle region before reduction

    typedef enum logic [1:0] {
        VAR_X,                                  // X update slot
        VAR_Y,                                  // Y update slot
        VAR_Z                                   // Z update slot
    } cordic_var_e;

    typedef enum logic [2:0] {
        IDLE, LOAD, FETCH, SHIFT, ADD, OUT, DONE
    } cordic_state_e;

    typedef struct packed {
        logic    operation;                     // 1 for sine and 0 for cosine
        region_t region;                        // Region flag of the angle
        fix_t    angle;                         // Reduced angle in radians
    } cordic_req_t;

    typedef struct packed {
        fix_t x_sh;                             // X >>> i
        fix_t y_sh;                             // Y >>> i
        fix_t atan;                             // atan(2^-i) from the table
        logic sign;                             // Sign of Z picks the direction
    } step_t;

    typedef struct packed {
        logic load_req;                         // Capture start inputs
        logic load_xyz;                         // Load X/Y/Z stage registers
        logic load_step;                        // Register shift stage word
        logic add_en;                           // Write add/sub result
        logic load_out;                         // Register corrected output
    } ctrl_t;

endpackage

/* hw/cordic_ctrl.sv */
`timescale 1ns/10ps

module cordic_ctrl
    import cordic_pkg::*;
(
    input  logic        clk,                    // System clock
    input  logic        arst_n,                 // Async reset, active low
    input  logic        beg_fsm_cordic,         // Start pulse
    input  logic        ack_cordic,             // Result taken by consumer
    output ctrl_t       ctrl,                   // Datapath enables
    output iter_t       iter,                   // Current micro-rotation
    output cordic_var_e var_sel,                // Variable in the adder
    output logic        ready_cordic            // Result valid
);

    cordic_state_e state;                       // Current state
    cordic_state_e state_nxt;                   // Next state
    iter_t         iter_cnt;                    // Iteration counter
    cordic_var_e   var_cnt;                     // Variable counter
    logic          last_var;                    // Z add in progress
    logic          last_iter;                   // Final micro-rotation

    assign last_var  = (var_cnt == VAR_Z);
    assign last_iter = &iter_cnt;

    // ======================================================================
    // State register and next state
    // ======================================================================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;                      // Hold by default
        case (state)
            IDLE:   if (beg_fsm_cordic) state_nxt = LOAD;
            LOAD:   state_nxt = FETCH;
            FETCH:  state_nxt = SHIFT;
            SHIFT:  state_nxt = ADD;
            ADD:
            begin
                if (last_var)                   // Three adds done
                    state_nxt = last_iter ? OUT : FETCH;
            end
            OUT:    state_nxt = DONE;
            DONE:   if (ack_cordic) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // ======================================================================
    // Iteration and variable counters
    // ======================================================================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            iter_cnt <= '0;
        else if (state == LOAD)
            iter_cnt <= '0;                     // New request starts at i = 0
        else if (state == ADD && last_var)
            iter_cnt <= iter_cnt + 1'b1;        // Step after Z update
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            var_cnt <= VAR_X;
        else if (state == LOAD)
            var_cnt <= VAR_X;
        else if (state == ADD)
            var_cnt <= last_var ? VAR_X : cordic_var_e'(var_cnt + 2'd1);  // X, Y, Z, wrap
    end

    // Enables are plain decodes of the state register
    assign ctrl.load_req  = (state == LOAD);
    assign ctrl.load_xyz  = (state == FETCH);
    assign ctrl.load_step = (state == SHIFT);
    assign ctrl.add_en    = (state == ADD);
    assign ctrl.load_out  = (state == OUT);

    assign ready_cordic = (state == DONE);      // Held until ack
    assign iter         = iter_cnt;
    assign var_sel      = var_cnt;

endmodule

/* hw/atan_rom.sv */
`timescale 1ns/10ps

module atan_rom
    import cordic_pkg::*;
(
    input  iter_t iter,                         // Table address
    output fix_t  atan                          // atan(2^-i) in Q2.14
);

    // Rounded to nearest LSB
    always_comb
    begin
        case (iter)
            4'd0:    atan = fix_t'(12868);      // pi/4
            4'd1:    atan = fix_t'(7596);
            4'd2:    atan = fix_t'(4014);
            4'd3:    atan = fix_t'(2037);
            4'd4:    atan = fix_t'(1023);
            4'd5:    atan = fix_t'(512);
            4'd6:    atan = fix_t'(256);
            4'd7:    atan = fix_t'(128);
            4'd8:    atan = fix_t'(64);
            4'd9:    atan = fix_t'(32);
            4'd10:   atan = fix_t'(16);
            4'd11:   atan = fix_t'(8);
            4'd12:   atan = fix_t'(4);
            4'd13:   atan = fix_t'(2);
            4'd14:   atan = fix_t'(1);
            4'd15:   atan = fix_t'(0);          // Below half an LSB
            default: atan = fix_t'(0);
        endcase
    end

endmodule

/* hw/cordic_datapath.sv */
`timescale 1ns/10ps

`include "cordic_settings.svh"

module cordic_datapath
    import cordic_pkg::*;
(
    input  logic        clk,                    // System clock
    input  logic        arst_n,                 // Async reset, active low
    input  ctrl_t       ctrl,                   // Stage enables
    input  iter_t       iter,                   // Current micro-rotation
    input  cordic_var_e var_sel,                // Variable in the adder
    input  cordic_req_t req_in,                 // Request from the ports
    output cordic_req_t req,                    // Captured request
    output fix_t        x_n,                    // X after last update
    output fix_t        y_n                     // Y after last update
);

    fix_t  x_r;                                 // X at start of iteration
    fix_t  y_r;                                 // Y at start of iteration
    fix_t  z_r;                                 // Z at start of iteration
    fix_t  z_n;                                 // Z after last update
    fix_t  atan;                                // Table output
    step_t step;                                // Shift stage register
    fix_t  op_a;                                // Adder operand A
    fix_t  op_b;                                // Adder operand B
    logic  sub;                                 // 1 selects A - B
    fix_t  sum;                                 // Add/sub result

    atan_rom atan_rom_i
    (
        .iter (iter),
        .atan (atan)
    );

    // ======================================================================
    // Request capture
    // ======================================================================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            req <= '0;
        else if (ctrl.load_req)
            req <= req_in;                      // Operation, region and angle
    end

    // ======================================================================
    // Fetch and shift stages
    // ======================================================================
    always_ff @(posedge clk)
    begin
        if (ctrl.load_xyz)
        begin
            if (iter == '0)
            begin
                x_r <= fix_t'(`CORDIC_X0);      // Gain-compensated unit vector
                y_r <= '0;
                z_r <= req.angle;               // Angle left to rotate
            end
            else
            begin
                x_r <= x_n;                     // Results of previous round
                y_r <= y_n;
                z_r <= z_n;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.load_step)
        begin
            step.x_sh <= x_r >>> iter;          // Arithmetic shift keeps sign
            step.y_sh <= y_r >>> iter;
            step.atan <= atan;
            step.sign <= z_r[`CORDIC_W-1];      // Rotation mode so sign of Z
        end
    end

    // ======================================================================
    // Operand selection and shared add/sub
    // ======================================================================
    // Z >= 0 means d = +1 which subtracts for X and Z and adds for Y
    always_comb
    begin
        case (var_sel)
            VAR_X:
            begin
                op_a = x_r;
                op_b = step.y_sh;
                sub  = ~step.sign;
            end
            VAR_Y:
            begin
                op_a = y_r;
                op_b = step.x_sh;
                sub  = step.sign;
            end
            default:
            begin
                op_a = z_r;
                op_b = step.atan;
                sub  = ~step.sign;
            end
        endcase
    end

    assign sum = sub ? (op_a - op_b) : (op_a + op_b);

    always_ff @(posedge clk)
    begin
        if (ctrl.add_en)
        begin
            case (var_sel)
                VAR_X:   x_n <= sum;
                VAR_Y:   y_n <= sum;
                default: z_n <= sum;
            endcase
        end
    end

endmodule

/* hw/quadrant_fix.sv */
`timescale 1ns/10ps

module quadrant_fix
    import cordic_pkg::*;
(
    input  logic        clk,                    // System clock
    input  logic        arst_n,                 // Async reset, active low
    input  logic        load_out,               // Register the result
    input  cordic_req_t req,                    // Operation and region
    input  fix_t        x_n,                    // Final X is cos of reduced angle
    input  fix_t        y_n,                    // Final Y is sin of reduced angle
    output fix_t        data_output             // Corrected result
);

    logic use_y;                                // Pick Y instead of X
    logic negate;                               // Flip the sign
    fix_t pick;                                 // Selected variable
    fix_t fixed;                                // After sign correction

    // Region decode {operation, region}
    always_comb
    begin
        case ({req.operation, req.region})
            3'b000:  {use_y, negate} = 2'b00;   // cos a
            3'b001:  {use_y, negate} = 2'b11;   // cos(a + pi/2) = -sin a
            3'b010:  {use_y, negate} = 2'b10;   // cos(a - pi/2) = sin a
            3'b011:  {use_y, negate} = 2'b01;   // cos(a + pi) = -cos a
            3'b100:  {use_y, negate} = 2'b10;   // sin a
            3'b101:  {use_y, negate} = 2'b00;   // sin(a + pi/2) = cos a
            3'b110:  {use_y, negate} = 2'b01;   // sin(a - pi/2) = -cos a
            default: {use_y, negate} = 2'b11;   // sin(a + pi) = -sin a
        endcase
    end

    assign pick  = use_y ? y_n : x_n;
    assign fixed = negate ? -pick : pick;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            data_output <= '0;
        else if (load_out)
            data_output <= fixed;               // Held through DONE
    end

endmodule

/* hw/cordic_top.sv */
`timescale 1ns/10ps

module cordic_top
    import cordic_pkg::*;
(
    input  logic    clk,                        // System clock
    input  logic    arst_n,                     // Async reset, active low
    input  logic    beg_fsm_cordic,             // Start pulse
    input  logic    ack_cordic,                 // Result taken
    input  logic    operation,                  // 1 for sine and 0 for cosine
    input  region_t shift_region_flag,          // Region of the true angle
    input  fix_t    data_in,                    // Reduced angle in Q2.14
    output logic    ready_cordic,               // Result valid
    output fix_t    data_output                 // Sine or cosine in Q2.14
);

    ctrl_t       ctrl;                          // Stage enables
    iter_t       iter;                          // Micro-rotation index
    cordic_var_e var_sel;                       // Variable in the adder
    cordic_req_t req_in;                        // Packed request inputs
    cordic_req_t req;                           // Captured request
    fix_t        x_n;                           // Final X
    fix_t        y_n;                           // Final Y

    assign req_in = '{operation: operation, region: shift_region_flag, angle: data_in};

    cordic_ctrl cordic_ctrl_i
    (
        .clk            (clk),
        .arst_n         (arst_n),
        .beg_fsm_cordic (beg_fsm_cordic),
        .ack_cordic     (ack_cordic),
        .ctrl           (ctrl),
        .iter           (iter),
        .var_sel        (var_sel),
        .ready_cordic   (ready_cordic)
    );

    cordic_datapath cordic_datapath_i
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .ctrl    (ctrl),
        .iter    (iter),
        .var_sel (var_sel),
        .req_in  (req_in),
        .req     (req),
        .x_n     (x_n),
        .y_n     (y_n)
    );

    quadrant_fix quadrant_fix_i
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_out    (ctrl.load_out),
        .req         (req),
        .x_n         (x_n),
        .y_n         (y_n),
        .data_output (data_output)
    );

endmodule

/* dv/cordic_tb.sv */
`timescale 1ns/10ps

`include "cordic_settings.svh"

module cordic_tb
    import cordic_pkg::*;
();

    localparam int  ROWS    = 56;                   // 2 operations x 4 regions x 7 angles
    localparam int  LATENCY = 82;                   // Start edge to ready
    localparam int  TOL     = 12;                   // Allowed error in LSB
    localparam real SCALE   = 2.0 ** `CORDIC_FRAC;
    localparam real PI      = 3.14159265358979;

    logic        clk;
    logic        arst_n;
    logic        beg;
    logic        ack;
    logic        operation;
    region_t     region;
    fix_t        data_in;
    logic        ready;
    fix_t        data_output;
    logic [31:0] lfsr;                              // Random state

    logic        op_tab  [ROWS];                    // Stimulus and expected values
    region_t     reg_tab [ROWS];
    fix_t        ang_tab [ROWS];
    real         exp_tab [ROWS];
    fix_t        fixed_ang [4] = '{16'sd0, 16'sd8192, -16'sd13107, 16'sd24000};

    cordic_top dut_i
    (
        .clk               (clk),
        .arst_n            (arst_n),
        .beg_fsm_cordic    (beg),
        .ack_cordic        (ack),
        .operation         (operation),
        .shift_region_flag (region),
        .data_in           (data_in),
        .ready_cordic      (ready),
        .data_output       (data_output)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;                     // 40 ns period
    end

    // ======================================================================
    // Reference model and random angles
    // ======================================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
    endfunction

    function automatic fix_t rand_angle();
        logic signed [15:0] r;
        int                 v;
        for (int b = 0; b < 16; b++)
        begin
            lfsr = lfsr_next(lfsr);                 // One step per bit
            r    = {r[14:0], lfsr[0]};
        end
        v = r;
        return fix_t'((v * 3) / 4);                 // Scale into +-1.5 rad
    endfunction

    function automatic real true_value(input logic op, input region_t rg, input fix_t ang);
        real a;
        a = $itor(ang) / SCALE;
        case (rg)
            2'b01:   a = a + PI / 2.0;
            2'b10:   a = a - PI / 2.0;
            2'b11:   a = a + PI;
            default: a = a;
        endcase
        return op ? $sin(a) : $cos(a);
    endfunction

    task automatic fill_table();
        int k;
        k = 0;
        for (int op = 0; op < 2; op++)
            for (int rg = 0; rg < 4; rg++)
                for (int n = 0; n < 7; n++)
                begin
                    op_tab[k]  = op[0];
                    reg_tab[k] = region_t'(rg);
                    ang_tab[k] = (n < 4) ? fixed_ang[n] : rand_angle();
                    exp_tab[k] = true_value(op_tab[k], reg_tab[k], ang_tab[k]);
                    k++;
                end
    endtask

    // ======================================================================
    // Checks
    // ======================================================================
    task automatic check_fix(input string name, input fix_t got, input fix_t exp, input int tol);
        int d;
        d = int'(got) - int'(exp);
        if (d < -tol || d > tol)
        begin
            $display("ERR %s got %h exp %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERR %s got %h exp %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("ERR %s got %h exp %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // ======================================================================
    // Transactions
    // ======================================================================
    task automatic run_row(input int k, input bit poke);
        int cycles;
        @(posedge clk);
        beg       <= 1'b1;
        operation <= op_tab[k];
        region    <= reg_tab[k];
        data_in   <= ang_tab[k];
        @(posedge clk);                             // DUT sees the start here
        beg       <= 1'b0;
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
            if (cycles == 1)
            begin
                data_in   <= '0;                    // Request was taken in LOAD
                operation <= ~op_tab[k];
                region    <= ~reg_tab[k];
            end
            if (poke)
                beg <= (cycles == 40);              // Stray start mid-run
            @(negedge clk);
            if (cycles > 2 * LATENCY)
            begin
                $display("Timed out waiting for ready_cordic after a start");
                $display("Some tests failed");
                $fatal(1);
            end
        end
        while (ready !== 1'b1);
        check_count("ready_cordic latency", cycles, LATENCY);
        check_fix("data_output", data_output, fix_t'(int'(exp_tab[k] * SCALE)), TOL);
    endtask

    task automatic acknowledge(input int delay, input bit poke);
        fix_t held;
        held = data_output;
        for (int n = 0; n < delay; n++)
        begin
            @(posedge clk);
            beg <= poke && (n == 5);                // Stray start while in DONE
            @(negedge clk);
            check_bit("ready_cordic", ready, 1'b1);
            check_fix("data_output", data_output, held, 0);
        end
        @(posedge clk);
        ack <= 1'b1;
        @(posedge clk);                             // Ack seen so FSM returns to IDLE
        ack <= 1'b0;
        @(negedge clk);
        check_bit("ready_cordic", ready, 1'b0);
        check_fix("data_output", data_output, held, 0);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial
    begin
        arst_n    = 1'b0;
        beg       = 1'b0;
        ack       = 1'b0;
        operation = 1'b0;
        region    = '0;
        data_in   = '0;
        lfsr      = 32'hd53f_432f;
        fill_table();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_bit("ready_cordic", ready, 1'b0);
        check_fix("data_output", data_output, '0, 0);
        for (int k = 0; k < ROWS; k++)
        begin
            run_row(k, 1'b0);
            acknowledge(0, 1'b0);
        end
        run_row(5, 1'b1);                           // Late ack with stray starts
        acknowledge(20, 1'b1);
        run_row(33, 1'b0);                          // New start after ack
        acknowledge(0, 1'b0);
        $display("All tests passed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hw
hw/cordic_pkg.sv
hw/cordic_ctrl.sv
hw/atan_rom.sv
hw/cordic_datapath.sv
hw/quadrant_fix.sv
hw/cordic_top.sv
dv/cordic_tb.sv
